//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_backprop_stack
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
src/bp_pkg.sv
src/delay_line.sv
src/delta_calculator.sv
src/sample_store.sv
src/update_sequencer.sv
src/gradient_accumulator.sv
src/backprop_stack.sv
tests/tb_backprop_stack.sv

//--- src/backprop_stack.sv
`timescale 1ns/100ps

module backprop_stack import bp_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,

    // training samples
    input  logic               train_valid_i,
    input  logic [LAYER_W-1:0] train_layer_i,
    input  logic [ROW_W-1:0]   train_slot_i,
    input  vec_t               diff_act_i,
    input  vec_t               diff_cost_i,
    input  vec_t               diff_start_i,

    // update requests
    input  logic               update_req_i,
    input  logic [LAYER_W-1:0] update_layer_i,
    output logic               update_busy_o,

    // gradient rows
    output logic               update_valid_o,
    output logic [LAYER_W-1:0] update_layer_o,
    output logic [ROW_W-1:0]   update_row_o,
    output vec_t               update_value_o
);

    vec_t               delta;
    vec_t               act;
    wr_info_t           wr_info;
    vec_t               rd_delta [LANES];
    vec_t               rd_act [LANES];
    logic [LAYER_W-1:0] rd_layer;
    logic [ROW_W-1:0]   row;
    upd_info_t          upd_tag;

    delta_calculator i_delta_calculator (
        .clk           (clk),
        .reset_i       (reset_i),
        .train_valid_i (train_valid_i),
        .train_layer_i (train_layer_i),
        .train_slot_i  (train_slot_i),
        .diff_act_i    (diff_act_i),
        .diff_cost_i   (diff_cost_i),
        .diff_start_i  (diff_start_i),
        .delta_o       (delta),
        .act_o         (act),
        .wr_info_o     (wr_info)
    );

    sample_store i_sample_store (
        .clk        (clk),
        .wr_info_i  (wr_info),
        .delta_i    (delta),
        .act_i      (act),
        .rd_layer_i (rd_layer),
        .rd_delta_o (rd_delta),
        .rd_act_o   (rd_act)
    );

    update_sequencer i_update_sequencer (
        .clk            (clk),
        .reset_i        (reset_i),
        .update_req_i   (update_req_i),
        .update_layer_i (update_layer_i),
        .busy_o         (update_busy_o),
        .rd_layer_o     (rd_layer),
        .row_o          (row),
        .tag_o          (upd_tag)
    );

    gradient_accumulator i_gradient_accumulator (
        .clk        (clk),
        .row_i      (row),
        .rd_delta_i (rd_delta),
        .rd_act_i   (rd_act),
        .value_o    (update_value_o)
    );

    // tag fields become the output strobe and labels
    assign update_valid_o = upd_tag.valid;
    assign update_layer_o = upd_tag.layer;
    assign update_row_o   = upd_tag.row;

endmodule

//--- src/bp_pkg.sv
package bp_pkg;

    // fixed-point format
    localparam int DATA_W    = 16;
    localparam int FRAC_BITS = 8;

    // one lane per row, slot and column
    localparam int LANES      = 3;
    localparam int MAX_LAYERS = 4;

    localparam int LAYER_W = 2;
    localparam int ROW_W   = 2;

    typedef logic signed [DATA_W-1:0] elem_t;

    // element 0 sits in the top slice of the vector
    typedef elem_t [0:LANES-1] vec_t;

    typedef struct packed {
        logic               valid;
        logic [LAYER_W-1:0] layer;
        logic [ROW_W-1:0]   slot;
    } wr_info_t;

    typedef struct packed {
        logic               valid;
        logic [LAYER_W-1:0] layer;
        logic [ROW_W-1:0]   row;
    } upd_info_t;

    // full signed product, scaled back to the element format
    function automatic elem_t fx_mult(elem_t a, elem_t b);
        logic signed [2*DATA_W-1:0] full;
        logic signed [2*DATA_W-1:0] scaled;
        full   = a * b;
        scaled = full >>> FRAC_BITS;
        return scaled[DATA_W-1:0];
    endfunction

    // wraps at DATA_W bits
    function automatic elem_t fx_add(elem_t a, elem_t b);
        elem_t sum;
        sum = a + b;
        return sum;
    endfunction

endpackage

//--- src/delay_line.sv
`timescale 1ns/100ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  LATENCY   = 1
) (
    input  logic     clk,
    input  logic     reset_i,
    input  payload_t in_i,
    output payload_t out_o
);

    payload_t stage_q [LATENCY];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < LATENCY; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= in_i;
            for (int i = 1; i < LATENCY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign out_o = stage_q[LATENCY-1];

endmodule

//--- src/delta_calculator.sv
`timescale 1ns/100ps

module delta_calculator import bp_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               train_valid_i,
    input  logic [LAYER_W-1:0] train_layer_i,
    input  logic [ROW_W-1:0]   train_slot_i,
    input  vec_t               diff_act_i,
    input  vec_t               diff_cost_i,
    input  vec_t               diff_start_i,
    output vec_t               delta_o,
    output vec_t               act_o,
    output wr_info_t           wr_info_o
);

    wr_info_t wr_tag;
    vec_t     delta_next;

    // lane-wise product of cost and activation derivative
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            delta_next[l] = fx_mult(diff_cost_i[l], diff_act_i[l]);
        end
    end

    always_ff @(posedge clk) begin
        delta_o <= delta_next;
        act_o   <= diff_start_i;
    end

    assign wr_tag.valid = train_valid_i;
    assign wr_tag.layer = train_layer_i;
    assign wr_tag.slot  = train_slot_i;

    // tag follows the payload register by one cycle
    delay_line #(
        .payload_t (wr_info_t),
        .LATENCY   (1)
    ) i_wr_delay (
        .clk     (clk),
        .reset_i (reset_i),
        .in_i    (wr_tag),
        .out_o   (wr_info_o)
    );

endmodule

//--- src/gradient_accumulator.sv
`timescale 1ns/100ps

module gradient_accumulator import bp_pkg::*; (
    input  logic             clk,
    input  logic [ROW_W-1:0] row_i,
    input  vec_t             rd_delta_i [LANES],
    input  vec_t             rd_act_i [LANES],
    output vec_t             value_o
);

    vec_t grad_next;

    // column j: sum over slots of delta_i[row] * a_i[j]
    always_comb begin : row_sum
        elem_t acc;
        for (int j = 0; j < LANES; j++) begin
            // slot 0 seeds the sum
            acc = fx_mult(rd_delta_i[0][row_i], rd_act_i[0][j]);
            for (int i = 1; i < LANES; i++) begin
                acc = fx_add(acc, fx_mult(rd_delta_i[i][row_i], rd_act_i[i][j]));
            end
            grad_next[j] = acc;
        end
    end

    always_ff @(posedge clk) begin
        value_o <= grad_next;
    end

endmodule

//--- src/sample_store.sv
`timescale 1ns/100ps

module sample_store import bp_pkg::*; (
    input  logic               clk,
    input  wr_info_t           wr_info_i,
    input  vec_t               delta_i,
    input  vec_t               act_i,
    input  logic [LAYER_W-1:0] rd_layer_i,
    output vec_t               rd_delta_o [LANES],
    output vec_t               rd_act_o [LANES]
);

    // one entry per layer and slot
    vec_t delta_mem [MAX_LAYERS][LANES];
    vec_t act_mem   [MAX_LAYERS][LANES];

    logic wr_en;

    // slot codes past the last lane are dropped
    assign wr_en = wr_info_i.valid && (wr_info_i.slot < ROW_W'(LANES));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            delta_mem[wr_info_i.layer][wr_info_i.slot] <= delta_i;
            act_mem[wr_info_i.layer][wr_info_i.slot]   <= act_i;
        end
    end

    // every slot of the selected layer at once
    always_comb begin
        for (int s = 0; s < LANES; s++) begin
            rd_delta_o[s] = delta_mem[rd_layer_i][s];
            rd_act_o[s]   = act_mem[rd_layer_i][s];
        end
    end

endmodule

//--- src/update_sequencer.sv
`timescale 1ns/100ps

module update_sequencer import bp_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               update_req_i,
    input  logic [LAYER_W-1:0] update_layer_i,
    output logic               busy_o,
    output logic [LAYER_W-1:0] rd_layer_o,
    output logic [ROW_W-1:0]   row_o,
    output upd_info_t          tag_o
);

    logic               accept;
    logic [ROW_W-1:0]   cnt_q;
    logic [LAYER_W-1:0] layer_q;
    logic               issue_valid_q;
    upd_info_t          issue_tag;

    assign accept = update_req_i && !busy_o;

    // row counter, runs while busy
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_o  <= 1'b0;
            cnt_q   <= '0;
            layer_q <= '0;
        end else if (accept) begin
            busy_o  <= 1'b1;
            cnt_q   <= '0;
            layer_q <= update_layer_i;
        end else if (busy_o) begin
            if (cnt_q == ROW_W'(LANES - 1)) begin
                busy_o <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // issue stage drives the store read and the accumulator
    always_ff @(posedge clk) begin
        if (reset_i) begin
            issue_valid_q <= 1'b0;
            rd_layer_o    <= '0;
            row_o         <= '0;
        end else begin
            issue_valid_q <= busy_o;
            rd_layer_o    <= layer_q;
            row_o         <= cnt_q;
        end
    end

    assign issue_tag.valid = issue_valid_q;
    assign issue_tag.layer = rd_layer_o;
    assign issue_tag.row   = row_o;

    // lines up with the accumulator register
    delay_line #(
        .payload_t (upd_info_t),
        .LATENCY   (1)
    ) i_tag_delay (
        .clk     (clk),
        .reset_i (reset_i),
        .in_i    (issue_tag),
        .out_o   (tag_o)
    );

endmodule

//--- tests/tb_backprop_stack.sv
`timescale 1ns/100ps

module tb_backprop_stack import bp_pkg::*; ();

    localparam int ACCEPT_TIMEOUT = 20;
    localparam int IDLE_TIMEOUT   = 50;

    logic               clk;
    logic               reset_i;
    logic               train_valid_i;
    logic [LAYER_W-1:0] train_layer_i;
    logic [ROW_W-1:0]   train_slot_i;
    vec_t               diff_act_i;
    vec_t               diff_cost_i;
    vec_t               diff_start_i;
    logic               update_req_i;
    logic [LAYER_W-1:0] update_layer_i;
    logic               update_busy_o;
    logic               update_valid_o;
    logic [LAYER_W-1:0] update_layer_o;
    logic [ROW_W-1:0]   update_row_o;
    vec_t               update_value_o;

    // model of the sample store
    vec_t m_delta [MAX_LAYERS][LANES];
    vec_t m_act   [MAX_LAYERS][LANES];

    // rows still owed by the DUT and the edge each one is due after
    int                 exp_edge_q [$];
    logic [LAYER_W-1:0] exp_layer_q [$];
    logic [ROW_W-1:0]   exp_row_q [$];
    vec_t               exp_val_q [$];

    logic [31:0] lfsr_q = 32'h23a1;
    int edge_cnt = 0;
    int valid_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int test_num = 1;
    int test_fail_start = 0;

    backprop_stack i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // small values stay within about +-1.0
    function automatic vec_t rand_vec(bit full);
        vec_t        v;
        logic [15:0] b;
        for (int l = 0; l < LANES; l++) begin
            if (full) begin
                b = rand_bits(16);
            end else begin
                b = rand_bits(9);
                b = {{7{b[8]}}, b[8:0]};
            end
            v[l] = elem_t'(b);
        end
        return v;
    endfunction

    function automatic elem_t ref_mult(elem_t a, elem_t b);
        longint prod;
        prod = longint'(a) * longint'(b);
        // floor of the scaled product, wrapped to the element width
        prod = prod >>> FRAC_BITS;
        return elem_t'(prod[DATA_W-1:0]);
    endfunction

    function automatic elem_t ref_add(elem_t a, elem_t b);
        int sum;
        sum = int'(a) + int'(b);
        return elem_t'(sum[DATA_W-1:0]);
    endfunction

    // entry j of row r: sum over slots of delta_i[r] * a_i[j]
    function automatic vec_t expected_row(int layer, int row);
        vec_t  res;
        elem_t acc;
        for (int j = 0; j < LANES; j++) begin
            acc = ref_mult(m_delta[layer][0][row], m_act[layer][0][j]);
            for (int i = 1; i < LANES; i++) begin
                acc = ref_add(acc, ref_mult(m_delta[layer][i][row], m_act[layer][i][j]));
            end
            res[j] = acc;
        end
        return res;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic write_sample(int layer, int slot, bit full);
        vec_t d_act;
        vec_t d_cost;
        vec_t start;
        d_act  = rand_vec(full);
        d_cost = rand_vec(full);
        start  = rand_vec(full);
        @(posedge clk);
        train_valid_i <= 1'b1;
        train_layer_i <= LAYER_W'(layer);
        train_slot_i  <= ROW_W'(slot);
        diff_act_i    <= d_act;
        diff_cost_i   <= d_cost;
        diff_start_i  <= start;
        for (int l = 0; l < LANES; l++) begin
            m_delta[layer][slot][l] = ref_mult(d_cost[l], d_act[l]);
        end
        m_act[layer][slot] = start;
    endtask

    // gap so the last write lands before any request is sampled
    task automatic end_writes();
        @(posedge clk);
        train_valid_i <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // returns on the edge that takes the request, still driving it
    task automatic request_update(int layer);
        int n;
        @(posedge clk);
        update_req_i   <= 1'b1;
        update_layer_i <= LAYER_W'(layer);
        n = 0;
        @(negedge clk);
        while (update_busy_o && n < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (update_busy_o) begin
            $display("request for layer %0d was never accepted", layer);
            fail_cnt++;
        end
        @(posedge clk);
    endtask

    task automatic wait_idle(string what);
        int n;
        n = 0;
        @(posedge clk);
        while ((exp_edge_q.size() != 0 || update_busy_o) && n < IDLE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_edge_q.size() != 0 || update_busy_o) begin
            $display("timeout while waiting for the results of %s", what);
            fail_cnt++;
        end
    endtask

    task automatic finish_test(string name);
        $display("test %0d %s: %s, %0d errors", test_num, name,
                 (fail_cnt == test_fail_start) ? "passed" : "failed",
                 fail_cnt - test_fail_start);
        test_num++;
        test_fail_start = fail_cnt;
    endtask

    // inputs and outputs only move on rising edges, so look at them in between
    initial begin : compare_results
        logic [LAYER_W-1:0] layer;
        logic [ROW_W-1:0]   row;
        vec_t               val;
        logic               busy_exp;
        int                 busy_end;
        busy_end = -1;
        forever begin
            @(negedge clk);
            if (exp_edge_q.size() != 0 && exp_edge_q[0] == edge_cnt) begin
                layer = exp_layer_q.pop_front();
                row   = exp_row_q.pop_front();
                val   = exp_val_q.pop_front();
                void'(exp_edge_q.pop_front());
                if (!update_valid_o) begin
                    $display("row %0d of layer %0d did not arrive on time", row, layer);
                    fail_cnt++;
                end else begin
                    check_value("update_layer_o", 32'(update_layer_o), 32'(layer));
                    check_value("update_row_o", 32'(update_row_o), 32'(row));
                    for (int j = 0; j < LANES; j++) begin
                        check_value($sformatf("update_value_o[%0d]", j),
                                    32'(update_value_o[j]), 32'(val[j]));
                    end
                end
            end else if (update_valid_o) begin
                $display("unexpected result for layer %0d row %0d",
                         update_layer_o, update_row_o);
                fail_cnt++;
            end
            if (update_valid_o) valid_cnt++;
            // busy holds for LANES cycles after each accepted request
            busy_exp = (edge_cnt <= busy_end);
            if (!reset_i) begin
                check_value("update_busy_o", 32'(update_busy_o), 32'(busy_exp));
            end
            // taken at the next edge, row r due two edges plus r later
            if (!reset_i && update_req_i && !busy_exp) begin
                busy_end = edge_cnt + LANES;
                for (int r = 0; r < LANES; r++) begin
                    exp_layer_q.push_back(update_layer_i);
                    exp_row_q.push_back(ROW_W'(r));
                    exp_val_q.push_back(expected_row(int'(update_layer_i), r));
                    exp_edge_q.push_back(edge_cnt + 3 + r);
                end
            end
        end
    end

    initial begin
        int valid_start;
        reset_i        = 1'b1;
        train_valid_i  = 1'b0;
        train_layer_i  = '0;
        train_slot_i   = '0;
        diff_act_i     = '0;
        diff_cost_i    = '0;
        diff_start_i   = '0;
        update_req_i   = 1'b0;
        update_layer_i = '0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        @(negedge clk);
        check_value("update_valid_o", 32'(update_valid_o), 32'd0);
        check_value("update_busy_o", 32'(update_busy_o), 32'd0);
        for (int s = 0; s < LANES; s++) write_sample(0, s, 1'b0);
        end_writes();
        request_update(0);
        update_req_i <= 1'b0;
        wait_idle("layer 0");
        finish_test("single layer");

        // slot-major order interleaves the layers
        for (int s = 0; s < LANES; s++) begin
            for (int l = 0; l < MAX_LAYERS; l++) write_sample(l, s, 1'b0);
        end
        end_writes();
        for (int l = 0; l < MAX_LAYERS; l++) request_update(l);
        update_req_i <= 1'b0;
        wait_idle("all layers");
        finish_test("all layers");

        write_sample(2, 1, 1'b0);
        end_writes();
        request_update(2);
        update_req_i <= 1'b0;
        wait_idle("layer 2");
        finish_test("slot overwrite");

        for (int s = 0; s < LANES; s++) begin
            write_sample(3, s, 1'b1);
            write_sample(1, s, 1'b1);
        end
        end_writes();
        request_update(3);
        request_update(1);
        update_req_i <= 1'b0;
        wait_idle("full range layers");
        finish_test("full range");

        valid_start = valid_cnt;
        request_update(0);
        @(posedge clk);
        update_layer_i <= 2'd3;
        @(negedge clk);
        check_value("update_busy_o", 32'(update_busy_o), 32'd1);
        @(posedge clk);
        update_req_i <= 1'b0;
        wait_idle("request while busy");
        repeat (2 * LANES + 2) @(posedge clk);
        check_value("update_valid_o count", 32'(valid_cnt - valid_start), 32'(LANES));
        finish_test("request while busy");

        $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
